// File: radiant_pkg.sv
`default_nettype none

package radiant_pkg;

    // bus widths
    localparam int WB_ADR_W = 16;
    localparam int WB_DAT_W = 32;

    // master to slave, single classic cycles
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [3:0]          sel;
        logic [WB_DAT_W-1:0] dat;
    } wb_m2s_t;

    // slave to master, no retry
    typedef struct packed {
        logic                ack;
        logic                err;
        logic [WB_DAT_W-1:0] dat;
    } wb_s2m_t;

    // region codes from adr[15:12]
    localparam logic [3:0] REGION_ID     = 4'd0;
    localparam logic [3:0] REGION_THRESH = 4'd1;
    localparam logic [3:0] REGION_SCAL   = 4'd2;

    // date half: 2-digit year, month, day
    typedef struct packed {
        logic [6:0] year;
        logic [3:0] month;
        logic [4:0] day;
    } fw_date_t;

    typedef struct packed {
        logic [3:0] major;
        logic [3:0] minor;
        logic [7:0] rev;
    } fw_version_t;

    typedef struct packed {
        fw_date_t    date;
        fw_version_t version;
    } date_version_fields_t;

    // same word, raw for the bus or split into fields
    typedef union packed {
        logic [WB_DAT_W-1:0]  raw;
        date_version_fields_t f;
    } date_version_u;

    localparam logic [31:0] IDENT_DEFAULT = "RDNT";
    localparam int NUM_CHANNELS_DEFAULT = 24;
    // 1 = trigger comes in on the inverted side
    localparam logic [23:0] TRIG_POLARITY_DEFAULT = 24'b011011001001001010010110;
    localparam int SCALER_W = 16;

    // reset values
    localparam logic [WB_DAT_W-1:0] REG_RESET = '0;
    localparam logic [SCALER_W-1:0] SCALER_RESET = '0;
    localparam wb_s2m_t WB_S2M_IDLE = '{ack: 1'b0, err: 1'b0, dat: '0};

    function automatic logic [3:0] wb_region(input logic [WB_ADR_W-1:0] adr);
        return adr[15:12];
    endfunction

    // word offset inside a region
    function automatic logic [9:0] wb_offset(input logic [WB_ADR_W-1:0] adr);
        return adr[11:2];
    endfunction

    // merge enabled byte lanes of a write into the old word
    function automatic logic [WB_DAT_W-1:0] wb_apply_sel(
        input logic [WB_DAT_W-1:0] old_word,
        input logic [WB_DAT_W-1:0] new_word,
        input logic [3:0]          sel
    );
        logic [WB_DAT_W-1:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: radiant_wb_intercon.sv
`timescale 1ns/1ns
`default_nettype none

module radiant_wb_intercon (
    input  wire                  sysclk,
    input  wire                  rst_n_i,
    input  radiant_pkg::wb_m2s_t wb_i,
    output radiant_pkg::wb_s2m_t wb_o,
    output radiant_pkg::wb_m2s_t id_wb_o,
    output radiant_pkg::wb_m2s_t thresh_wb_o,
    output radiant_pkg::wb_m2s_t scal_wb_o,
    input  radiant_pkg::wb_s2m_t id_wb_i,
    input  radiant_pkg::wb_s2m_t thresh_wb_i,
    input  radiant_pkg::wb_s2m_t scal_wb_i
);

    logic [3:0] region;
    logic       hit_id;
    logic       hit_thresh;
    logic       hit_scal;
    logic       unmapped;
    logic       err_req;
    logic       err_q;

    assign region     = radiant_pkg::wb_region(wb_i.adr);
    assign hit_id     = (region == radiant_pkg::REGION_ID);
    assign hit_thresh = (region == radiant_pkg::REGION_THRESH);
    assign hit_scal   = (region == radiant_pkg::REGION_SCAL);
    assign unmapped   = !(hit_id || hit_thresh || hit_scal);

    // everything but stb fans out unchanged
    always_comb begin
        id_wb_o         = wb_i;
        id_wb_o.stb     = wb_i.stb && hit_id;
        thresh_wb_o     = wb_i;
        thresh_wb_o.stb = wb_i.stb && hit_thresh;
        scal_wb_o       = wb_i;
        scal_wb_o.stb   = wb_i.stb && hit_scal;
    end

    // unmapped cycle answers like a slave would
    assign err_req = wb_i.cyc && wb_i.stb && unmapped && !err_q;

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= err_req;
        end
    end

    // address held until the answer, so mux on live region
    always_comb begin
        if (hit_id) begin
            wb_o = id_wb_i;
        end else if (hit_thresh) begin
            wb_o = thresh_wb_i;
        end else if (hit_scal) begin
            wb_o = scal_wb_i;
        end else begin
            wb_o     = radiant_pkg::WB_S2M_IDLE;
            wb_o.err = err_q;
        end
    end

    // slaves and err register never answer together
    assert property (@(posedge sysclk) disable iff (!rst_n_i)
        !(err_q && (id_wb_i.ack || thresh_wb_i.ack || scal_wb_i.ack)));

    // err only after an unmapped request
    assert property (@(posedge sysclk) disable iff (!rst_n_i)
        wb_o.err |-> $past(wb_i.cyc && wb_i.stb && unmapped));

endmodule

`default_nettype wire

// File: radiant_id_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module radiant_id_ctrl #(
    parameter logic [31:0] IDENT         = radiant_pkg::IDENT_DEFAULT,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd0,
    parameter logic [7:0]  VER_REV       = 8'd0,
    parameter int          NUM_CHANNELS  = radiant_pkg::NUM_CHANNELS_DEFAULT,
    parameter int          HEARTBEAT_BIT = 23
) (
    input  wire                     sysclk,
    input  wire                     rst_n_i,
    input  radiant_pkg::wb_m2s_t    wb_i,
    output radiant_pkg::wb_s2m_t    wb_o,
    output logic [NUM_CHANNELS-1:0] channel_disable_o,
    output logic                    led_o
);

    radiant_pkg::date_version_u dv;

    logic                    req;
    logic                    ack_q;
    logic [31:0]             dat_q;
    logic [9:0]              offset;
    logic [31:0]             rd_data;
    logic [31:0]             wr_data;
    logic [NUM_CHANNELS-1:0] chan_disable_q;
    logic [HEARTBEAT_BIT:0]  hb_cnt;

    // packed date/version, fields filled one by one
    always_comb begin
        dv.f.date.year     = FIRMWARE_DATE[15:9];
        dv.f.date.month    = FIRMWARE_DATE[8:5];
        dv.f.date.day      = FIRMWARE_DATE[4:0];
        dv.f.version.major = VER_MAJOR;
        dv.f.version.minor = VER_MINOR;
        dv.f.version.rev   = VER_REV;
    end

    assign req    = wb_i.cyc && wb_i.stb && !ack_q;
    assign offset = radiant_pkg::wb_offset(wb_i.adr);

    // read mux, unmapped offsets read zero
    always_comb begin
        case (offset)
            10'd0:   rd_data = IDENT;
            10'd1:   rd_data = dv.raw;
            10'd2:   rd_data = 32'(chan_disable_q);
            default: rd_data = '0;
        endcase
    end

    assign wr_data = radiant_pkg::wb_apply_sel(rd_data, wb_i.dat, wb_i.sel);

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q          <= 1'b0;
            chan_disable_q <= radiant_pkg::REG_RESET[NUM_CHANNELS-1:0];
        end else begin
            ack_q <= req;
            // only the mask is writable
            if (req && wb_i.we && offset == 10'd2) begin
                chan_disable_q <= wr_data[NUM_CHANNELS-1:0];
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    always_comb begin
        wb_o     = radiant_pkg::WB_S2M_IDLE;
        wb_o.ack = ack_q;
        wb_o.dat = dat_q;
    end

    assign channel_disable_o = chan_disable_q;

    // free-running heartbeat
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign led_o = hb_cnt[HEARTBEAT_BIT];

    // ack only after a request aimed at the id region
    assert property (@(posedge sysclk) disable iff (!rst_n_i)
        ack_q |-> $past(wb_i.cyc && wb_i.stb
                        && radiant_pkg::wb_region(wb_i.adr) == radiant_pkg::REGION_ID));

endmodule

`default_nettype wire

// File: radiant_trig_scalers.sv
`timescale 1ns/1ns
`default_nettype none

module radiant_trig_scalers #(
    parameter int                      NUM_CHANNELS  = radiant_pkg::NUM_CHANNELS_DEFAULT,
    parameter logic [NUM_CHANNELS-1:0] TRIG_POLARITY = radiant_pkg::TRIG_POLARITY_DEFAULT
) (
    input  wire                     sysclk,
    input  wire                     rst_n_i,
    input  radiant_pkg::wb_m2s_t    wb_i,
    output radiant_pkg::wb_s2m_t    wb_o,
    input  wire [NUM_CHANNELS-1:0]  trig_i,
    input  wire                     pps_i,
    input  wire [NUM_CHANNELS-1:0]  channel_disable_i
);

    localparam int SW = radiant_pkg::SCALER_W;

    logic [NUM_CHANNELS-1:0] trig_s1;
    logic [NUM_CHANNELS-1:0] trig_s2;
    logic [NUM_CHANNELS-1:0] trig_pol;
    logic [NUM_CHANNELS-1:0] trig_d;
    logic [NUM_CHANNELS-1:0] trig_rise;
    logic                    pps_s1;
    logic                    pps_s2;
    logic                    pps_d;
    logic                    pps_edge;

    logic [NUM_CHANNELS-1:0][SW-1:0] cnt_q;
    logic [NUM_CHANNELS-1:0][SW-1:0] latched_q;
    logic [SW-1:0]                   pps_count_q;

    logic        req;
    logic        ack_q;
    logic [31:0] dat_q;
    logic [9:0]  offset;
    logic [31:0] rd_data;

    // two-stage sync, idle level after reset is the polarity bit
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trig_s1 <= TRIG_POLARITY;
            trig_s2 <= TRIG_POLARITY;
            trig_d  <= '0;
            pps_s1  <= 1'b0;
            pps_s2  <= 1'b0;
            pps_d   <= 1'b0;
        end else begin
            trig_s1 <= trig_i;
            trig_s2 <= trig_s1;
            trig_d  <= trig_pol;
            pps_s1  <= pps_i;
            pps_s2  <= pps_s1;
            pps_d   <= pps_s2;
        end
    end

    // corrected so a trigger is always a rising edge
    assign trig_pol  = trig_s2 ^ TRIG_POLARITY;
    assign trig_rise = trig_pol & ~trig_d & ~channel_disable_i;
    assign pps_edge  = pps_s2 && !pps_d;

    // live counters, latch and clear on pps
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q       <= {NUM_CHANNELS{radiant_pkg::SCALER_RESET}};
            latched_q   <= {NUM_CHANNELS{radiant_pkg::SCALER_RESET}};
            pps_count_q <= radiant_pkg::SCALER_RESET;
        end else if (pps_edge) begin
            // an edge landing here is lost
            latched_q   <= cnt_q;
            cnt_q       <= {NUM_CHANNELS{radiant_pkg::SCALER_RESET}};
            pps_count_q <= pps_count_q + 1'b1;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                // saturate at full scale
                if (trig_rise[i] && cnt_q[i] != {SW{1'b1}}) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // bus side, read only
    assign req    = wb_i.cyc && wb_i.stb && !ack_q;
    assign offset = radiant_pkg::wb_offset(wb_i.adr);

    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (offset == 10'(i)) begin
                rd_data = 32'(latched_q[i]);
            end
        end
        if (offset == 10'd63) begin
            rd_data = 32'(pps_count_q);
        end
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // writes get the ack and nothing else
    always_ff @(posedge sysclk) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    always_comb begin
        wb_o     = radiant_pkg::WB_S2M_IDLE;
        wb_o.ack = ack_q;
        wb_o.dat = dat_q;
    end

    // latched bank moves only on a pps edge
    assert property (@(posedge sysclk) disable iff (!rst_n_i)
        !$stable(latched_q) |-> $past(pps_edge));

endmodule

`default_nettype wire

// File: radiant_thresh_pwm.sv
`timescale 1ns/1ns
`default_nettype none

module radiant_thresh_pwm #(
    parameter int NUM_CHANNELS = radiant_pkg::NUM_CHANNELS_DEFAULT,
    parameter int PWM_BITS     = 8
) (
    input  wire                     sysclk,
    input  wire                     rst_n_i,
    input  radiant_pkg::wb_m2s_t    wb_i,
    output radiant_pkg::wb_s2m_t    wb_o,
    output logic [NUM_CHANNELS-1:0] thresh_pwm_o
);

    logic [NUM_CHANNELS-1:0][PWM_BITS-1:0] thresh_q;
    logic [NUM_CHANNELS-1:0][PWM_BITS-1:0] active_q;
    logic [NUM_CHANNELS-1:0][PWM_BITS-1:0] cmp_val;
    logic [PWM_BITS-1:0]                   pwm_cnt;
    logic                                  period_start;
    logic [NUM_CHANNELS-1:0]               pwm_q;

    logic        req;
    logic        ack_q;
    logic [31:0] dat_q;
    logic [9:0]  offset;
    logic [31:0] rd_data;
    logic [31:0] wr_data;

    assign req    = wb_i.cyc && wb_i.stb && !ack_q;
    assign offset = radiant_pkg::wb_offset(wb_i.adr);

    // threshold readback, upper bits zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (offset == 10'(i)) begin
                rd_data = 32'(thresh_q[i]);
            end
        end
    end

    assign wr_data = radiant_pkg::wb_apply_sel(rd_data, wb_i.dat, wb_i.sel);

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            thresh_q <= {NUM_CHANNELS{radiant_pkg::REG_RESET[PWM_BITS-1:0]}};
        end else begin
            ack_q <= req;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (req && wb_i.we && offset == 10'(i)) begin
                    thresh_q[i] <= wr_data[PWM_BITS-1:0];
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    always_comb begin
        wb_o     = radiant_pkg::WB_S2M_IDLE;
        wb_o.ack = ack_q;
        wb_o.dat = dat_q;
    end

    assign period_start = (pwm_cnt == '0);

    // at count zero compare against the value being loaded
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cmp_val[i] = period_start ? thresh_q[i] : active_q[i];
        end
    end

    // one shared counter, threshold high cycles per period
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_cnt  <= '0;
            active_q <= {NUM_CHANNELS{radiant_pkg::REG_RESET[PWM_BITS-1:0]}};
            pwm_q    <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (period_start) begin
                active_q <= thresh_q;
            end
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                pwm_q[i] <= (pwm_cnt < cmp_val[i]);
            end
        end
    end

    assign thresh_pwm_o = pwm_q;

endmodule

`default_nettype wire

// File: radiant_top.sv
`timescale 1ns/1ns
`default_nettype none

module radiant_top #(
    parameter int                      NUM_CHANNELS  = radiant_pkg::NUM_CHANNELS_DEFAULT,
    parameter logic [NUM_CHANNELS-1:0] TRIG_POLARITY = radiant_pkg::TRIG_POLARITY_DEFAULT,
    parameter int                      PWM_BITS      = 8,
    parameter int                      HEARTBEAT_BIT = 23,
    parameter logic [31:0]             IDENT         = radiant_pkg::IDENT_DEFAULT,
    // year[15:9] month[8:5] day[4:0]
    parameter logic [15:0]             FIRMWARE_DATE = 16'h0000,
    parameter logic [3:0]              VER_MAJOR     = 4'd0,
    parameter logic [3:0]              VER_MINOR     = 4'd2,
    parameter logic [7:0]              VER_REV       = 8'd26
) (
    input  wire                     sysclk,
    input  wire                     rst_n_i,
    input  radiant_pkg::wb_m2s_t    wb_i,
    output radiant_pkg::wb_s2m_t    wb_o,
    input  wire [NUM_CHANNELS-1:0]  trig_i,
    input  wire                     pps_i,
    output logic [NUM_CHANNELS-1:0] thresh_pwm_o,
    output logic                    led_o
);

    radiant_pkg::wb_m2s_t id_m2s;
    radiant_pkg::wb_m2s_t thresh_m2s;
    radiant_pkg::wb_m2s_t scal_m2s;
    radiant_pkg::wb_s2m_t id_s2m;
    radiant_pkg::wb_s2m_t thresh_s2m;
    radiant_pkg::wb_s2m_t scal_s2m;

    // mask from id block gates the scalers
    logic [NUM_CHANNELS-1:0] channel_disable;

    radiant_wb_intercon u_intercon (
        .sysclk      (sysclk),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_i),
        .wb_o        (wb_o),
        .id_wb_o     (id_m2s),
        .thresh_wb_o (thresh_m2s),
        .scal_wb_o   (scal_m2s),
        .id_wb_i     (id_s2m),
        .thresh_wb_i (thresh_s2m),
        .scal_wb_i   (scal_s2m)
    );

    radiant_id_ctrl #(
        .IDENT         (IDENT),
        .FIRMWARE_DATE (FIRMWARE_DATE),
        .VER_MAJOR     (VER_MAJOR),
        .VER_MINOR     (VER_MINOR),
        .VER_REV       (VER_REV),
        .NUM_CHANNELS  (NUM_CHANNELS),
        .HEARTBEAT_BIT (HEARTBEAT_BIT)
    ) u_id (
        .sysclk            (sysclk),
        .rst_n_i           (rst_n_i),
        .wb_i              (id_m2s),
        .wb_o              (id_s2m),
        .channel_disable_o (channel_disable),
        .led_o             (led_o)
    );

    radiant_trig_scalers #(
        .NUM_CHANNELS  (NUM_CHANNELS),
        .TRIG_POLARITY (TRIG_POLARITY)
    ) u_scalers (
        .sysclk            (sysclk),
        .rst_n_i           (rst_n_i),
        .wb_i              (scal_m2s),
        .wb_o              (scal_s2m),
        .trig_i            (trig_i),
        .pps_i             (pps_i),
        .channel_disable_i (channel_disable)
    );

    radiant_thresh_pwm #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .PWM_BITS     (PWM_BITS)
    ) u_thresh (
        .sysclk       (sysclk),
        .rst_n_i      (rst_n_i),
        .wb_i         (thresh_m2s),
        .wb_o         (thresh_s2m),
        .thresh_pwm_o (thresh_pwm_o)
    );

endmodule

`default_nettype wire

// File: tb_radiant_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_radiant_top;

    localparam int              CLK_PERIOD = 20;
    localparam int              NCH        = radiant_pkg::NUM_CHANNELS_DEFAULT;
    localparam logic [NCH-1:0]  POL        = radiant_pkg::TRIG_POLARITY_DEFAULT;
    localparam int              PWM_BITS   = 8;
    localparam int              HB_BIT     = 4;
    localparam logic [31:0]     SEED       = 32'h89cd2a31;

    // firmware stamp handed to the DUT
    localparam logic [6:0]      FW_YEAR    = 7'd25;
    localparam logic [3:0]      FW_MONTH   = 4'd6;
    localparam logic [4:0]      FW_DAY     = 5'd14;
    localparam logic [3:0]      FW_MAJOR   = 4'd1;
    localparam logic [3:0]      FW_MINOR   = 4'd3;
    localparam logic [7:0]      FW_REV     = 8'd42;

    // worst-case cycle budget per test
    localparam int BUS_OP_MAX  = 18;
    localparam int ID_LEN      = 3 * BUS_OP_MAX;
    localparam int REG_LEN     = (2 * NCH + 16) * BUS_OP_MAX;
    localparam int PWM_LEN     = 2 * BUS_OP_MAX + 260 + 256;
    localparam int SCAL_LEN    = 20 * 6 + 8 + 3 + 8 + (NCH + 2) * BUS_OP_MAX;
    localparam int CLEAR_LEN   = 3 + 8 + (NCH + 2) * BUS_OP_MAX;
    localparam int HB_LEN      = 80;
    localparam int WDOG_CYCLES = 3 + ID_LEN + REG_LEN + PWM_LEN + SCAL_LEN + CLEAR_LEN
                               + HB_LEN + 500;

    logic                 sysclk;
    logic                 rst_n_i;
    radiant_pkg::wb_m2s_t wb_m2s;
    radiant_pkg::wb_s2m_t wb_s2m;
    logic [NCH-1:0]       trig;
    logic                 pps;
    logic [NCH-1:0]       pwm;
    logic                 led;

    // shared between tests
    logic [NCH-1:0]       disable_mask;
    logic [7:0]           thr [NCH];
    // pps pulses since reset, the DUT counter starts at zero
    int                   pps_sent;

    radiant_top #(
        .NUM_CHANNELS  (NCH),
        .TRIG_POLARITY (POL),
        .PWM_BITS      (PWM_BITS),
        .HEARTBEAT_BIT (HB_BIT),
        .IDENT         (radiant_pkg::IDENT_DEFAULT),
        .FIRMWARE_DATE ({FW_YEAR, FW_MONTH, FW_DAY}),
        .VER_MAJOR     (FW_MAJOR),
        .VER_MINOR     (FW_MINOR),
        .VER_REV       (FW_REV)
    ) UUT (
        .sysclk       (sysclk),
        .rst_n_i      (rst_n_i),
        .wb_i         (wb_m2s),
        .wb_o         (wb_s2m),
        .trig_i       (trig),
        .pps_i        (pps),
        .thresh_pwm_o (pwm),
        .led_o        (led)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s, read %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // region in 15:12, word offset in 11:2
    function automatic logic [15:0] reg_addr(input logic [3:0] region, input int offset);
        return {region, 10'(offset), 2'b00};
    endfunction

    // one classic cycle, request held until ack or err
    task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat,
                             output logic got_err);
        int waited;
        waited = 0;
        @(negedge sysclk);
        wb_m2s.cyc = 1'b1;
        wb_m2s.stb = 1'b1;
        wb_m2s.we  = we;
        wb_m2s.adr = adr;
        wb_m2s.sel = sel;
        wb_m2s.dat = wdat;
        do begin
            @(negedge sysclk);
            waited++;
        end while (!wb_s2m.ack && !wb_s2m.err && waited < 16);
        if (!wb_s2m.ack && !wb_s2m.err) begin
            abort_run($sformatf("no bus answer within 16 cycles at address %h", adr));
        end
        rdat    = wb_s2m.dat;
        got_err = wb_s2m.err;
        // stb drops in the cycle after the answer
        wb_m2s  = '0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel);
        logic [31:0] unused_rd;
        logic        got_err;
        bus_cycle(1'b1, adr, wdat, sel, unused_rd, got_err);
        if (got_err) begin
            abort_run($sformatf("bus error on write to address %h", adr));
        end
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [31:0] rdat);
        logic got_err;
        bus_cycle(1'b0, adr, '0, 4'hf, rdat, got_err);
        if (got_err) begin
            abort_run($sformatf("bus error on read from address %h", adr));
        end
    endtask

    task automatic wb_read_expect_err(input logic [15:0] adr);
        logic [31:0] unused_rd;
        logic        got_err;
        bus_cycle(1'b0, adr, '0, 4'hf, unused_rd, got_err);
        if (!got_err) begin
            abort_run($sformatf("read from unmapped address %h was acked", adr));
        end
    endtask

    task automatic pulse_pps();
        pps = 1'b1;
        pps_sent++;
        repeat (3) @(negedge sysclk);
        pps = 1'b0;
    endtask

    task automatic test_ident();
        radiant_pkg::date_version_u exp_dv;
        logic [31:0]                rd;
        exp_dv.f.date.year     = FW_YEAR;
        exp_dv.f.date.month    = FW_MONTH;
        exp_dv.f.date.day      = FW_DAY;
        exp_dv.f.version.major = FW_MAJOR;
        exp_dv.f.version.minor = FW_MINOR;
        exp_dv.f.version.rev   = FW_REV;
        wb_read(reg_addr(radiant_pkg::REGION_ID, 0), rd);
        check_equal(rd, radiant_pkg::IDENT_DEFAULT, "identifier");
        wb_read(reg_addr(radiant_pkg::REGION_ID, 1), rd);
        check_equal(rd, exp_dv.raw, "date/version word");
    endtask

    task automatic test_registers();
        logic [31:0]    rd;
        logic [31:0]    junk;
        logic [NCH-1:0] mask;
        mask = NCH'($urandom);
        wb_write(reg_addr(radiant_pkg::REGION_ID, 2), 32'(mask), 4'hf);
        wb_read(reg_addr(radiant_pkg::REGION_ID, 2), rd);
        check_equal(rd, 32'(mask), "disable mask full write");
        // byte 1 alone
        junk = $urandom;
        wb_write(reg_addr(radiant_pkg::REGION_ID, 2), junk, 4'b0010);
        mask[15:8] = junk[15:8];
        wb_read(reg_addr(radiant_pkg::REGION_ID, 2), rd);
        check_equal(rd, 32'(mask), "disable mask sel 0010");
        // bytes 0 and 2, byte 3 has no bits behind it
        junk = $urandom;
        wb_write(reg_addr(radiant_pkg::REGION_ID, 2), junk, 4'b1101);
        mask[7:0]   = junk[7:0];
        mask[23:16] = junk[23:16];
        wb_read(reg_addr(radiant_pkg::REGION_ID, 2), rd);
        check_equal(rd, 32'(mask), "disable mask sel 1101");
        disable_mask = mask;

        // random thresholds with junk in the upper bits
        for (int ch = 0; ch < NCH; ch++) begin
            thr[ch] = 8'($urandom);
            wb_write(reg_addr(radiant_pkg::REGION_THRESH, ch), {24'($urandom), thr[ch]}, 4'hf);
        end
        for (int ch = 0; ch < NCH; ch++) begin
            wb_read(reg_addr(radiant_pkg::REGION_THRESH, ch), rd);
            check_equal(rd, {24'h0, thr[ch]}, $sformatf("threshold %0d readback", ch));
        end
        // lane 0 disabled leaves threshold alone
        wb_write(reg_addr(radiant_pkg::REGION_THRESH, 3), 32'hffff_ffff, 4'b1110);
        wb_read(reg_addr(radiant_pkg::REGION_THRESH, 3), rd);
        check_equal(rd, {24'h0, thr[3]}, "threshold 3 after sel 1110");
        wb_write(reg_addr(radiant_pkg::REGION_THRESH, 3), 32'hffff_ff5c, 4'b0001);
        thr[3] = 8'h5c;
        wb_read(reg_addr(radiant_pkg::REGION_THRESH, 3), rd);
        check_equal(rd, {24'h0, thr[3]}, "threshold 3 after sel 0001");

        // region 3 is unmapped, bus must recover after it
        wb_read_expect_err(reg_addr(4'd3, 0));
        wb_read(reg_addr(radiant_pkg::REGION_ID, 0), rd);
        check_equal(rd, radiant_pkg::IDENT_DEFAULT, "identifier after bus error");
    endtask

    task automatic test_pwm();
        int hi_count [NCH];
        // the two corner values
        thr[6] = 8'd0;
        thr[7] = 8'd255;
        wb_write(reg_addr(radiant_pkg::REGION_THRESH, 6), 32'(thr[6]), 4'hf);
        wb_write(reg_addr(radiant_pkg::REGION_THRESH, 7), 32'(thr[7]), 4'hf);
        // let a new period pick up the values
        repeat (260) @(negedge sysclk);
        for (int ch = 0; ch < NCH; ch++) begin
            hi_count[ch] = 0;
        end
        repeat (256) begin
            @(negedge sysclk);
            for (int ch = 0; ch < NCH; ch++) begin
                if (pwm[ch]) begin
                    hi_count[ch]++;
                end
            end
        end
        for (int ch = 0; ch < NCH; ch++) begin
            check_equal(32'(hi_count[ch]), 32'(thr[ch]), $sformatf("pwm %0d high cycles", ch));
        end
    endtask

    task automatic test_scalers();
        int          pulses [NCH];
        logic [31:0] rd;
        for (int ch = 0; ch < NCH; ch++) begin
            pulses[ch] = int'($urandom % 21);
        end
        // all channels pulse together, 3 active then 3 idle
        for (int p = 0; p < 20; p++) begin
            for (int ch = 0; ch < NCH; ch++) begin
                trig[ch] = POL[ch] ^ (pulses[ch] > p);
            end
            repeat (3) @(negedge sysclk);
            trig = POL;
            repeat (3) @(negedge sysclk);
        end
        repeat (8) @(negedge sysclk);
        pulse_pps();
        repeat (8) @(negedge sysclk);
        for (int ch = 0; ch < NCH; ch++) begin
            wb_read(reg_addr(radiant_pkg::REGION_SCAL, ch), rd);
            check_equal(rd, disable_mask[ch] ? 32'd0 : 32'(pulses[ch]),
                        $sformatf("scaler %0d count", ch));
        end
        wb_read(reg_addr(radiant_pkg::REGION_SCAL, 63), rd);
        check_equal(rd, 32'(pps_sent), "pps counter after first pps");
    endtask

    task automatic test_clearing();
        logic [31:0] rd;
        pulse_pps();
        repeat (8) @(negedge sysclk);
        for (int ch = 0; ch < NCH; ch++) begin
            wb_read(reg_addr(radiant_pkg::REGION_SCAL, ch), rd);
            check_equal(rd, 32'd0, $sformatf("scaler %0d after quiet second", ch));
        end
        wb_read(reg_addr(radiant_pkg::REGION_SCAL, 63), rd);
        check_equal(rd, 32'(pps_sent), "pps counter after second pps");
    endtask

    task automatic test_heartbeat();
        logic last;
        int   since;
        last  = led;
        since = 0;
        repeat (HB_LEN) begin
            @(negedge sysclk);
            if (led != last) begin
                last  = led;
                since = 0;
            end else begin
                since++;
            end
            if (since >= 40) begin
                abort_run("heartbeat led held the same value for 40 cycles");
            end
        end
    endtask

    initial begin
        sysclk       = 1'b0;
        rst_n_i      = 1'b0;
        wb_m2s       = '0;
        trig         = POL;
        pps          = 1'b0;
        disable_mask = '0;
        pps_sent     = 0;
        void'($urandom(SEED));
        repeat (3) @(negedge sysclk);
        rst_n_i = 1'b1;
        check_equal(32'(led), 32'd0, "led right after reset");
        test_ident();
        test_registers();
        test_pwm();
        test_scalers();
        test_clearing();
        test_heartbeat();
        $display("TEST RESULT: PASS");
        $finish;
    end

    // sized from the per-test budgets above
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: verilog.f
radiant_pkg.sv
radiant_wb_intercon.sv
radiant_id_ctrl.sv
radiant_trig_scalers.sv
radiant_thresh_pwm.sv
radiant_top.sv
tb_radiant_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, pass only if the simulator printed the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_radiant_top -f verilog.f \
    && ./obj_dir/Vtb_radiant_top | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
